/* rtl/core_pkg.sv */
package core_pkg;

    localparam int data_width     = 32; // Width of every general register.
    localparam int reg_addr_width = 4;  // Sixteen registers R0 to R15.
    localparam int pc_width       = 11; // Program counter bits kept in R15.
    localparam int mem_addr_width = 6;  // Word index into the 64-word data memory.
    localparam int queue_depth    = 4;  // Queue entries and the sender's starting credits.

    // Micro-operation codes as produced by the decoder.
    typedef enum logic [3:0] {
        op_add = 4'd0,  // Rd = Rn + shifted Rm.
        op_sub = 4'd1,  // Rd = Rn - shifted Rm.
        op_and = 4'd2,  // Rd = Rn & shifted Rm.
        op_orr = 4'd3,  // Rd = Rn | shifted Rm.
        op_eor = 4'd4,  // Rd = Rn ^ shifted Rm.
        op_mov = 4'd5,  // Rd = shifted Rm.
        op_ldr = 4'd6,  // Rd = mem[Rn + shifted Rm].
        op_str = 4'd7,  // mem[Rn + shifted Rm] = Rd.
        op_b   = 4'd8   // PC = Rn + shifted Rm.
    } opcode_e;

    // Barrel shifter modes applied to the Rm operand.
    typedef enum logic [1:0] {
        sh_lsl = 2'd0, // Logical shift left.
        sh_lsr = 2'd1, // Logical shift right.
        sh_asr = 2'd2, // Arithmetic shift right.
        sh_ror = 2'd3  // Rotate right.
    } shift_e;

    // Source of the next R15 value, encoded as in the register file.
    typedef enum logic [1:0] {
        pc_inc    = 2'd0, // Advance by one.
        pc_start  = 2'd1, // Load the external start address.
        pc_branch = 2'd3  // Load the branch target from the datapath.
    } pc_sel_e;

    // One decoded micro-operation, 22 bits in all.
    typedef struct packed {
        opcode_e                   opcode; // Operation to perform.
        logic [reg_addr_width-1:0] rd;     // Destination, or store data source.
        logic [reg_addr_width-1:0] rn;     // First operand.
        logic [reg_addr_width-1:0] rm;     // Second operand, which passes the shifter.
        logic [reg_addr_width-1:0] rs;     // Register holding the shift amount.
        shift_e                    shift;  // Shift mode for rm.
    } uop_t;

    // One register write, 37 bits in all.
    typedef struct packed {
        logic                      valid; // Write takes place this cycle.
        logic [reg_addr_width-1:0] addr;  // Target register.
        logic [data_width-1:0]     data;  // Value written.
    } wb_t;

endpackage : core_pkg

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::wb_t     alu_wb,     // Write port for data-processing results.
    input  core_pkg::wb_t     ldr_wb,     // Write port for load data.
    input  logic [3:0]        a_addr,
    input  logic [3:0]        b_addr,
    input  logic [3:0]        shift_addr,
    input  logic [3:0]        str_addr,
    input  logic [3:0]        dbg_addr,
    input  logic              load_pc,    // Update R15 at the next edge.
    input  core_pkg::pc_sel_e sel_pc,
    input  logic [10:0]       start_pc,
    input  logic [10:0]       dp_pc,      // Branch target from the ALU.
    output logic [31:0]       a_data,
    output logic [31:0]       b_data,
    output logic [31:0]       shift_data,
    output logic [31:0]       str_data,
    output logic [31:0]       dbg_data,
    output logic [10:0]       pc_out
);
    import core_pkg::*;

    localparam logic [reg_addr_width-1:0] pc_reg = 4'd15; // R15 holds the program counter.

    logic [data_width-1:0] regs [2**reg_addr_width]; // R0 to R15.
    logic [pc_width-1:0]   pc_next;                  // Value R15 takes when load_pc is set.

    // All reads are combinational.
    assign a_data     = regs[a_addr];
    assign b_data     = regs[b_addr];
    assign shift_data = regs[shift_addr];
    assign str_data   = regs[str_addr];
    assign dbg_data   = regs[dbg_addr]; // Only window on the register contents from outside.
    assign pc_out     = regs[pc_reg][pc_width-1:0];

    always_comb begin
        case (sel_pc)
            pc_start:  pc_next = start_pc;   // Start pulse.
            pc_branch: pc_next = dp_pc;      // Taken branch.
            default:   pc_next = pc_out + 1'b1; // Sequential issue.
        endcase
    end

    // Later assignments win, so the load port beats the ALU port
    // and the PC update beats both on R15.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0; // All registers start at zero.
            end
        end else begin
            if (alu_wb.valid) begin
                regs[alu_wb.addr] <= alu_wb.data;
            end
            if (ldr_wb.valid) begin
                regs[ldr_wb.addr] <= ldr_wb.data;
            end
            if (load_pc) begin
                regs[pc_reg] <= {{(data_width-pc_width){1'b0}}, pc_next}; // Upper bits stay zero.
            end
        end
    end

endmodule : regfile

/* rtl/uop_queue.sv */
`timescale 1ns/1ps

module uop_queue (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,          // Sender delivers a micro-operation.
    input  core_pkg::uop_t push_uop,
    input  logic           pop,           // Issue control consumes the head.
    output core_pkg::uop_t head,
    output logic           head_valid,
    output logic           credit_return  // One pulse per popped entry.
);
    import core_pkg::*;

    uop_t                             entries [queue_depth]; // Storage for queued micro-operations.
    logic [$clog2(queue_depth)-1:0]   wr_ptr;                // Next slot to write.
    logic [$clog2(queue_depth)-1:0]   rd_ptr;                // Current head slot.
    logic [$clog2(queue_depth+1)-1:0] count;                 // Entries held.
    logic                             do_push;
    logic                             do_pop;

    assign head       = entries[rd_ptr];
    assign head_valid = (count != '0);
    assign do_pop     = pop && head_valid; // Popping an empty queue is ignored.
    assign do_push    = push && ((count != queue_depth) || do_pop); // Credits keep this true.

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_uop; // Storage needs no reset.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr + do_push; // Pointers wrap at the power-of-two depth.
            rd_ptr        <= rd_ptr + do_pop;
            count         <= count + do_push - do_pop;
            credit_return <= do_pop; // Credit goes back one cycle after the pop.
        end
    end

endmodule : uop_queue

/* rtl/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::uop_t    head,
    input  logic              head_valid,
    input  logic              start,       // Start pulse that reloads the PC.
    output logic              pop,
    output core_pkg::uop_t    issue_uop,
    output logic              issue_valid,
    output logic [3:0]        a_addr,
    output logic [3:0]        b_addr,
    output logic [3:0]        shift_addr,
    output logic [3:0]        str_addr,
    output logic              load_pc,
    output core_pkg::pc_sel_e sel_pc
);
    import core_pkg::*;

    logic                      last_ld_valid; // A load issued in the previous cycle.
    logic [reg_addr_width-1:0] last_ld_rd;    // Its destination register.
    logic                      uses_ld_rd;    // Head reads the pending load's destination.
    logic                      hazard;

    // A store also reads rd as its data source.
    assign uses_ld_rd = (head.rn == last_ld_rd) || (head.rm == last_ld_rd) ||
                        (head.rs == last_ld_rd) ||
                        ((head.opcode == op_str) && (head.rd == last_ld_rd));
    assign hazard      = last_ld_valid && uses_ld_rd; // Wait one cycle for the load data.
    assign issue_valid = head_valid && !hazard;
    assign pop         = issue_valid; // Every issue frees one queue entry.
    assign issue_uop   = head;

    // Operand addresses come straight from the head so reads finish in the issue cycle.
    assign a_addr     = head.rn;
    assign b_addr     = head.rm;
    assign shift_addr = head.rs;
    assign str_addr   = head.rd;

    assign load_pc = start || issue_valid;

    always_comb begin
        if (start) begin
            sel_pc = pc_start; // Start overrides the step of a concurrent issue.
        end else if (issue_valid && (head.opcode == op_b)) begin
            sel_pc = pc_branch;
        end else begin
            sel_pc = pc_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_ld_valid <= 1'b0;
        end else begin
            last_ld_valid <= issue_valid && (head.opcode == op_ldr);
        end
        last_ld_rd <= head.rd; // Only read while last_ld_valid is set.
    end

endmodule : issue_ctrl

/* rtl/barrel_shifter.sv */
`timescale 1ns/1ps

module barrel_shifter (
    input  logic             [31:0] value,  // Rm operand.
    input  logic             [4:0]  amount, // Low bits of the Rs register.
    input  core_pkg::shift_e        shift,
    output logic             [31:0] result
);
    import core_pkg::*;

    // One stage of the log shifter, moving v by a fixed distance n.
    function automatic logic [data_width-1:0] shift_step(
        input logic [data_width-1:0] v,
        input int                    n,
        input shift_e                kind
    );
        case (kind)
            sh_lsl:  return v << n;
            sh_lsr:  return v >> n;
            sh_asr:  return $unsigned($signed(v) >>> n); // Sign bit fills from the top.
            sh_ror:  return (v >> n) | (v << (data_width - n)); // Bits shifted out reenter on top.
            default: return v;
        endcase
    endfunction

    // Five stages of 1, 2, 4, 8 and 16 positions, each enabled by one amount bit.
    always_comb begin
        logic [data_width-1:0] acc;
        acc = value;
        for (int i = 0; i < $bits(amount); i++) begin
            if (amount[i]) begin
                acc = shift_step(acc, 1 << i, shift);
            end
        end
        result = acc;
    end

endmodule : barrel_shifter

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  core_pkg::uop_t issue_uop,
    input  logic           issue_valid,
    input  logic [31:0]    a_data,      // Rn value.
    input  logic [31:0]    shifted_b,   // Rm after the barrel shifter.
    input  logic [31:0]    str_data_in, // Rd value for stores.
    output core_pkg::wb_t  alu_wb,
    output logic [10:0]    dp_pc,       // Branch target.
    output logic [5:0]     mem_addr,    // Data memory word index.
    output logic           store_en,
    output logic           load_en,
    output logic [31:0]    str_data
);
    import core_pkg::*;

    logic [data_width-1:0] sum;      // Shared adder for add, address and branch.
    logic [data_width-1:0] result;
    logic                  is_dp;    // Opcode writes a register through the ALU port.

    assign sum = a_data + shifted_b;

    always_comb begin
        case (issue_uop.opcode)
            op_add:  result = sum;
            op_sub:  result = a_data - shifted_b;
            op_and:  result = a_data & shifted_b;
            op_orr:  result = a_data | shifted_b;
            op_eor:  result = a_data ^ shifted_b;
            op_mov:  result = shifted_b;
            default: result = sum; // Loads, stores and branches use the sum.
        endcase
    end

    assign is_dp = (issue_uop.opcode inside {op_add, op_sub, op_and, op_orr, op_eor, op_mov});

    assign alu_wb.valid = issue_valid && is_dp;
    assign alu_wb.addr  = issue_uop.rd;
    assign alu_wb.data  = result;

    assign dp_pc = sum[pc_width-1:0]; // Regfile picks it only for a branch.

    // The sum is a byte address and the memory holds words.
    assign mem_addr = sum[mem_addr_width+1:2];
    assign store_en = issue_valid && (issue_uop.opcode == op_str);
    assign load_en  = issue_valid && (issue_uop.opcode == op_ldr);
    assign str_data = str_data_in;

endmodule : alu

/* rtl/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic [5:0]    mem_addr,  // Word index from the ALU.
    input  logic          store_en,
    input  logic          load_en,
    input  logic [31:0]   str_data,
    input  logic [3:0]    load_rd,   // Destination of the issuing load.
    output core_pkg::wb_t ldr_wb     // Load write-back, one cycle after issue.
);
    import core_pkg::*;

    logic [data_width-1:0] mem [2**mem_addr_width]; // 64 words of data memory.

    // Stores land at the edge that ends the issue cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**mem_addr_width; i++) begin
                mem[i] <= '0; // Memory comes out of reset cleared.
            end
        end else if (store_en) begin
            mem[mem_addr] <= str_data;
        end
    end

    // The read is registered, so the data is visible in the cycle after issue.
    always_ff @(posedge clk) begin
        if (rst) begin
            ldr_wb.valid <= 1'b0;
        end else begin
            ldr_wb.valid <= load_en;
        end
        if (load_en) begin
            ldr_wb.addr <= load_rd;       // Payload holds until the next load.
            ldr_wb.data <= mem[mem_addr];
        end
    end

endmodule : load_store_unit

/* rtl/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
    input  logic           clk,
    input  logic           rst,
    input  logic           uop_valid,     // Sender holds a credit and delivers uop.
    input  core_pkg::uop_t uop,
    output logic           credit_return,
    input  logic           start,
    input  logic [10:0]    start_pc,
    input  logic [3:0]     dbg_addr,
    output logic [31:0]    dbg_data,
    output logic [10:0]    pc_out,
    output core_pkg::wb_t  alu_wb_out,    // Also drives the regfile ALU port.
    output core_pkg::wb_t  ldr_wb_out     // Also drives the regfile load port.
);
    import core_pkg::*;

    uop_t                        head;         // Queue head offered to issue control.
    logic                        head_valid;
    logic                        pop;
    uop_t                        issue_uop;    // Micro-operation in its execute cycle.
    logic                        issue_valid;
    logic [reg_addr_width-1:0]   a_addr;
    logic [reg_addr_width-1:0]   b_addr;
    logic [reg_addr_width-1:0]   shift_addr;
    logic [reg_addr_width-1:0]   str_addr;
    logic                        load_pc;
    pc_sel_e                     sel_pc;
    logic [data_width-1:0]       a_data;
    logic [data_width-1:0]       b_data;
    logic [data_width-1:0]       shift_data;
    logic [data_width-1:0]       rf_str_data;  // Rd value read for a store.
    logic [data_width-1:0]       shifted_b;
    logic [pc_width-1:0]         dp_pc;
    logic [mem_addr_width-1:0]   mem_addr;
    logic                        store_en;
    logic                        load_en;
    logic [data_width-1:0]       st_data;      // Store data on its way to memory.

    uop_queue u_queue (
        .clk(clk), .rst(rst), .push(uop_valid), .push_uop(uop), .pop(pop),
        .head(head), .head_valid(head_valid), .credit_return(credit_return)
    );

    issue_ctrl u_issue (
        .clk(clk), .rst(rst), .head(head), .head_valid(head_valid), .start(start),
        .pop(pop), .issue_uop(issue_uop), .issue_valid(issue_valid),
        .a_addr(a_addr), .b_addr(b_addr), .shift_addr(shift_addr), .str_addr(str_addr),
        .load_pc(load_pc), .sel_pc(sel_pc)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst), .alu_wb(alu_wb_out), .ldr_wb(ldr_wb_out),
        .a_addr(a_addr), .b_addr(b_addr), .shift_addr(shift_addr), .str_addr(str_addr),
        .dbg_addr(dbg_addr), .load_pc(load_pc), .sel_pc(sel_pc), .start_pc(start_pc),
        .dp_pc(dp_pc), .a_data(a_data), .b_data(b_data), .shift_data(shift_data),
        .str_data(rf_str_data), .dbg_data(dbg_data), .pc_out(pc_out)
    );

    // Only the low five bits of Rs set the shift distance.
    barrel_shifter u_shifter (
        .value(b_data), .amount(shift_data[4:0]), .shift(issue_uop.shift), .result(shifted_b)
    );

    alu u_alu (
        .issue_uop(issue_uop), .issue_valid(issue_valid), .a_data(a_data),
        .shifted_b(shifted_b), .str_data_in(rf_str_data), .alu_wb(alu_wb_out), .dp_pc(dp_pc),
        .mem_addr(mem_addr), .store_en(store_en), .load_en(load_en), .str_data(st_data)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst(rst), .mem_addr(mem_addr), .store_en(store_en), .load_en(load_en),
        .str_data(st_data), .load_rd(issue_uop.rd), .ldr_wb(ldr_wb_out)
    );

endmodule : exec_core

/* verification/exec_core_properties.sv */
`timescale 1ns/1ps

module exec_core_properties (
    input logic              clk,
    input logic              rst,
    input logic              uop_valid,
    input logic              pop,
    input logic              credit_return,
    input logic              start,
    input logic [10:0]       start_pc,
    input logic [10:0]       pc_out,
    input logic [10:0]       dp_pc,
    input logic              issue_valid,
    input core_pkg::uop_t    issue_uop,
    input logic              load_en,
    input core_pkg::wb_t     alu_wb,
    input core_pkg::wb_t     ldr_wb
);
    import core_pkg::*;

    int outstanding; // Entries pushed and not yet popped.
    int failures;    // Assertion failures so far, summed up by the testbench.

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(uop_valid) - int'(pop);
        end
    end

    // Outputs are quiet in the cycle after a reset edge.
    reset_quiet: assert property (@(posedge clk)
        rst |=> !credit_return && !alu_wb.valid && !ldr_wb.valid)
    else begin
        $error("Outputs active right after reset");
        failures++;
    end

    never_overflow: assert property (@(posedge clk) disable iff (rst)
        outstanding <= queue_depth)
    else begin
        $error("More entries in flight than the queue holds");
        failures++;
    end

    credit_after_pop: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> $past(pop))
    else begin
        $error("Credit returned without a pop in the cycle before");
        failures++;
    end

    pop_gives_credit: assert property (@(posedge clk) disable iff (rst)
        pop |=> credit_return)
    else begin
        $error("Pop not followed by a credit");
        failures++;
    end

    load_wb_timing: assert property (@(posedge clk) disable iff (rst)
        load_en |=> ldr_wb.valid && (ldr_wb.addr == $past(issue_uop.rd)))
    else begin
        $error("Load write-back missing or to the wrong register");
        failures++;
    end

    pc_step: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !start && (issue_uop.opcode != op_b)
        |=> pc_out == 11'($past(pc_out) + 11'd1))
    else begin
        $error("PC did not step by one after an issue");
        failures++;
    end

    pc_branch_load: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !start && (issue_uop.opcode == op_b) |=> pc_out == $past(dp_pc))
    else begin
        $error("PC did not take the branch target");
        failures++;
    end

    pc_start_load: assert property (@(posedge clk) disable iff (rst)
        start |=> pc_out == $past(start_pc))
    else begin
        $error("PC did not load the start address");
        failures++;
    end

endmodule : exec_core_properties

bind exec_core exec_core_properties u_props (
    .clk(clk), .rst(rst), .uop_valid(uop_valid), .pop(pop), .credit_return(credit_return),
    .start(start), .start_pc(start_pc), .pc_out(pc_out), .dp_pc(dp_pc),
    .issue_valid(issue_valid), .issue_uop(issue_uop), .load_en(load_en),
    .alu_wb(alu_wb_out), .ldr_wb(ldr_wb_out)
);

/* verification/tb_exec_core.sv */
`timescale 1ns/1ps

module tb_exec_core;
    import core_pkg::*;

    localparam int max_cycles = 2000; // Two batches of 150 plus drains and margin.

    logic clk, rst, uop_valid, credit_return, start;
    logic [10:0] start_pc, pc_out;
    logic [3:0]  dbg_addr;
    logic [31:0] dbg_data;
    uop_t        uop;
    wb_t         alu_wb_out, ldr_wb_out;

    logic [15:0] lfsr = 16'd58;          // Galois LFSR state.
    logic [31:0] model_regs [16];        // Shadow register file.
    logic [31:0] model_mem [64];         // Shadow data memory.
    logic [10:0] model_pc;
    wb_t         exp_alu [$];            // Expected ALU write-backs in program order.
    wb_t         exp_ld [$];             // Expected load write-backs in program order.
    int          credits, cycles, mismatches, other_errors;
    logic        prev_ldr;
    logic [3:0]  prev_rd;

    exec_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;           // 4 ns period.
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400; // Feedback taps for a maximal 16-bit sequence.
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] shift_ref(input logic [31:0] v, input logic [4:0] a,
                                              input shift_e kind);
        case (kind)
            sh_lsl:  return v << a;
            sh_lsr:  return v >> a;
            sh_asr:  return $unsigned($signed(v) >>> a);
            default: return (a == 0) ? v : ((v >> a) | (v << (6'd32 - a)));
        endcase
    endfunction

    // Applies one micro-operation to the shadow state in program order.
    task automatic model_exec(input uop_t u);
        logic [31:0] a, sb, sum, res;
        a   = model_regs[u.rn];
        sb  = shift_ref(model_regs[u.rm], model_regs[u.rs][4:0], u.shift);
        sum = a + sb;
        case (u.opcode)
            op_add: res = sum;
            op_sub: res = a - sb;
            op_and: res = a & sb;
            op_orr: res = a | sb;
            op_eor: res = a ^ sb;
            default: res = sb;
        endcase
        if (u.opcode inside {op_add, op_sub, op_and, op_orr, op_eor, op_mov}) begin
            model_regs[u.rd] = res;
            exp_alu.push_back('{valid: 1'b1, addr: u.rd, data: res});
        end else if (u.opcode == op_ldr) begin
            model_regs[u.rd] = model_mem[sum[7:2]]; // Byte address to word index.
            exp_ld.push_back('{valid: 1'b1, addr: u.rd, data: model_mem[sum[7:2]]});
        end else if (u.opcode == op_str) begin
            model_mem[sum[7:2]] = model_regs[u.rd];
        end
        model_pc = (u.opcode == op_b) ? sum[10:0] : model_pc + 11'd1;
        model_regs[15] = {21'b0, model_pc};
    endtask

    function automatic uop_t make_uop();
        uop_t u;
        u.opcode = opcode_e'(4'(take_bits(4) % 9));
        u.rd     = 4'(take_bits(3));      // Destinations stay clear of R15.
        u.rn     = 4'(take_bits(4));
        u.rm     = 4'(take_bits(4));
        u.rs     = 4'(take_bits(4));
        u.shift  = shift_e'(2'(take_bits(2)));
        // A write right behind a load to the same register would lose to the load port.
        if (prev_ldr && (u.opcode inside {op_add, op_sub, op_and, op_orr, op_eor, op_mov, op_ldr})
            && (u.rd == prev_rd)) u.rd = u.rd ^ 4'd1;
        prev_ldr = (u.opcode == op_ldr);
        prev_rd  = u.rd;
        return u;
    endfunction

    // One clock of the credit-respecting sender.
    task automatic drive_cycle(input bit may_send);
        @(posedge clk);
        #1;
        if (credit_return) credits++;
        if (may_send && credits > 0) begin
            uop       = make_uop();
            uop_valid = 1'b1;
            credits--;
            model_exec(uop);
        end else begin
            uop_valid = 1'b0;
        end
    endtask

    task automatic run_batch(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            drive_cycle(1'b1);
            if (uop_valid) sent++;
        end
        do drive_cycle(1'b0);
        while (exp_alu.size() != 0 || exp_ld.size() != 0 || credits != queue_depth);
        repeat (2) drive_cycle(1'b0);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic pulse_start(input logic [10:0] addr);
        @(posedge clk);
        #1 start = 1'b1;
        start_pc = addr;
        @(posedge clk);
        #1 start = 1'b0;
        model_pc = addr;
        model_regs[15] = {21'b0, addr};
        check_value("pc_out", 32'(addr), 32'(pc_out));
    endtask

    // Write-backs are stable in the middle of the cycle.
    always @(negedge clk) begin
        if (!rst && alu_wb_out.valid) begin
            if (exp_alu.size() == 0) begin
                $display("Unexpected ALU write-back at %0t", $time);
                other_errors++;
            end else begin
                check_value("alu_wb_out.addr", 32'(exp_alu[0].addr), 32'(alu_wb_out.addr));
                check_value("alu_wb_out.data", exp_alu[0].data, alu_wb_out.data);
                void'(exp_alu.pop_front());
            end
        end
        if (!rst && ldr_wb_out.valid) begin
            if (exp_ld.size() == 0) begin
                $display("Unexpected load write-back at %0t", $time);
                other_errors++;
            end else begin
                check_value("ldr_wb_out.addr", 32'(exp_ld[0].addr), 32'(ldr_wb_out.addr));
                check_value("ldr_wb_out.data", exp_ld[0].data, ldr_wb_out.data);
                void'(exp_ld.pop_front());
            end
        end
    end

    initial begin
        rst          = 1'b1;
        uop_valid    = 1'b0;
        uop          = '0;
        start        = 1'b0;
        start_pc     = '0;
        dbg_addr     = '0;
        credits      = queue_depth;
        cycles       = 0;
        mismatches   = 0;
        other_errors = 0;
        prev_ldr     = 1'b0;
        prev_rd      = '0;
        model_pc     = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        pulse_start(11'h040);
        run_batch(150);
        check_value("pc_out", 32'(model_pc), 32'(pc_out));
        pulse_start(11'h7f0);             // Close to the top so the PC wraps.
        run_batch(150);
        check_value("pc_out", 32'(model_pc), 32'(pc_out));
        for (int i = 0; i < 16; i++) begin
            dbg_addr = 4'(i);
            #1 check_value($sformatf("dbg_data[r%0d]", i), model_regs[i], dbg_data);
        end
        $display("Closing report: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, other_errors, u_dut.u_props.failures);
        if (mismatches == 0 && other_errors == 0 && u_dut.u_props.failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_exec_core

/* vlog.f */
rtl/core_pkg.sv
rtl/regfile.sv
rtl/uop_queue.sv
rtl/issue_ctrl.sv
rtl/barrel_shifter.sv
rtl/alu.sv
rtl/load_store_unit.sv
rtl/exec_core.sv
verification/exec_core_properties.sv
verification/tb_exec_core.sv

/* run.sh */
#!/bin/sh
# Build and run the exec_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_core \
    -f vlog.f -o sim_exec_core || exit 1
./obj_dir/sim_exec_core > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed." || { echo "Simulation failed."; exit 1; }
